//--- Bender.yml
package:
  name: hazard_resolution_unit

sources:
  - include_dirs:
      - include
    files:
      - logic/hru_pkg.sv
      - logic/hru_hazard_detect.sv
      - logic/hru_hazard_state.sv
      - logic/hru_pipeline_ctrl.sv
      - logic/hazard_resolution_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/hru_clk_gen.sv
      - tb/hru_asserts.sv
      - tb/tb_hazard_resolution_unit.sv

//--- hazard_resolution_unit.f
+incdir+include
logic/hru_pkg.sv
logic/hru_hazard_detect.sv
logic/hru_hazard_state.sv
logic/hru_pipeline_ctrl.sv
logic/hazard_resolution_unit.sv
tb/hru_clk_gen.sv
tb/hru_asserts.sv
tb/tb_hazard_resolution_unit.sv

//--- include/hru_params.svh
`ifndef HRU_PARAMS_SVH
`define HRU_PARAMS_SVH

// Data width of the core and of the data memory address
`define HRU_XLEN 32

// Pipeline depth: IF, PD, ID, EX, MA, WB
`define HRU_NUM_STAGES 6

// Distance from the last stage to the stage where the PC becomes valid
// With six stages this lands on bit 2, the ID stage
`define HRU_PC_VALID_OFFSET 4

// MMIO window with read side effects (UART RX, FIFO pop)
`define HRU_MMIO_BASE 32'h4000_0000
`define HRU_MMIO_SIZE 32'h28

// Number of bubbles inserted for a load that hits the MMIO window
`define HRU_MMIO_STALL_CYCLES 2

`endif

//--- logic/hazard_resolution_unit.sv
`timescale 1ns/1ps

module hazard_resolution_unit (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_cache_reset_busy,
  input  logic             i_id_is_load,
  input  logic             i_id_is_multiply,
  input  logic             i_id_is_divide,
  input  logic             i_id_is_csr,
  input  hru_pkg::reg_idx_t i_id_dest_reg,
  input  hru_pkg::reg_idx_t i_pd_src1,
  input  hru_pkg::reg_idx_t i_pd_src2,
  input  logic             i_ex_div_busy,
  input  logic             i_ex_mul_done_next,
  input  logic             i_ex_branch_taken,
  input  logic             i_ma_is_load,
  input  hru_pkg::xlen_t    i_ma_addr,
  input  logic             i_stall_for_wfi,
  input  logic             i_trap_taken,
  input  logic             i_mret_taken,
  output logic             o_stall,
  output logic             o_flush,
  output logic             o_stall_registered,
  output logic             o_load_use_stall,
  output logic             o_mmio_read_pulse,
  output logic             o_rst_done,
  output logic             o_vld,
  output logic             o_pc_vld
);

  // Combinational hazard sources
  logic ld_potential_hazard;
  logic mul_div_stall;
  logic mmio_load_in_ma;

  // Registered hazard history
  logic mul_completing_q;
  logic csr_read_stall;
  logic mmio_stall;

  // Combined internal reset from the control stage
  logic pipeline_reset;

  hru_hazard_detect u_detect (
    .i_id_is_load          (i_id_is_load),
    .i_id_is_multiply      (i_id_is_multiply),
    .i_id_is_divide        (i_id_is_divide),
    .i_id_dest_reg         (i_id_dest_reg),
    .i_pd_src1             (i_pd_src1),
    .i_pd_src2             (i_pd_src2),
    .i_ex_div_busy         (i_ex_div_busy),
    .i_ma_is_load          (i_ma_is_load),
    .i_ma_addr             (i_ma_addr),
    .i_mul_completing_q    (mul_completing_q),
    .o_ld_potential_hazard (ld_potential_hazard),
    .o_mul_div_stall       (mul_div_stall),
    .o_mmio_load_in_ma     (mmio_load_in_ma)
  );

  hru_hazard_state u_state (
    .i_clk                 (i_clk),
    .i_pipeline_reset      (pipeline_reset),
    .i_pipeline_stall      (o_stall),
    .i_pipeline_flush      (o_flush),
    .i_ld_potential_hazard (ld_potential_hazard),
    .i_mul_div_stall       (mul_div_stall),
    .i_ex_mul_done_next    (i_ex_mul_done_next),
    .i_id_is_csr           (i_id_is_csr),
    .i_ma_is_load          (i_ma_is_load),
    .i_mmio_load_in_ma     (mmio_load_in_ma),
    .o_mul_completing_q    (mul_completing_q),
    .o_load_use_stall      (o_load_use_stall),
    .o_csr_read_stall      (csr_read_stall),
    .o_mmio_stall          (mmio_stall),
    .o_mmio_read_pulse     (o_mmio_read_pulse)
  );

  hru_pipeline_ctrl u_ctrl (
    .i_clk              (i_clk),
    .i_rst              (i_rst),
    .i_cache_reset_busy (i_cache_reset_busy),
    .i_mul_div_stall    (mul_div_stall),
    .i_load_use_stall   (o_load_use_stall),
    .i_csr_read_stall   (csr_read_stall),
    .i_mmio_stall       (mmio_stall),
    .i_stall_for_wfi    (i_stall_for_wfi),
    .i_ex_branch_taken  (i_ex_branch_taken),
    .i_trap_taken       (i_trap_taken),
    .i_mret_taken       (i_mret_taken),
    .o_pipeline_reset   (pipeline_reset),
    .o_stall            (o_stall),
    .o_flush            (o_flush),
    .o_stall_registered (o_stall_registered),
    .o_rst_done         (o_rst_done),
    .o_vld              (o_vld),
    .o_pc_vld           (o_pc_vld)
  );

endmodule : hazard_resolution_unit

//--- logic/hru_hazard_detect.sv
`timescale 1ns/1ps

`include "hru_params.svh"

module hru_hazard_detect (
  input  logic             i_id_is_load,
  input  logic             i_id_is_multiply,
  input  logic             i_id_is_divide,
  input  hru_pkg::reg_idx_t i_id_dest_reg,
  input  hru_pkg::reg_idx_t i_pd_src1,
  input  hru_pkg::reg_idx_t i_pd_src2,
  input  logic             i_ex_div_busy,
  input  logic             i_ma_is_load,
  input  hru_pkg::xlen_t    i_ma_addr,
  input  logic             i_mul_completing_q,
  output logic             o_ld_potential_hazard,
  output logic             o_mul_div_stall,
  output logic             o_mmio_load_in_ma
);

  import hru_pkg::*;

  // ====================================================================
  // Load-use match
  // ====================================================================

  // Compare the load's rd in ID/EX with the early source fields of PD
  // Both sides come straight from pipeline registers, so this is a short path
  logic dest_matches_src;
  assign dest_matches_src = (i_id_dest_reg == i_pd_src1) ||
                            (i_id_dest_reg == i_pd_src2);

  // Writes to x0 are discarded, so they never create a dependency
  assign o_ld_potential_hazard = i_id_is_load &&
                                 (i_id_dest_reg != reg_idx_t'(0)) &&
                                 dest_matches_src;

  // ====================================================================
  // MMIO window decode
  // ====================================================================

  // Offset from the window base, only meaningful once addr >= base
  xlen_t mmio_offset;
  assign mmio_offset = i_ma_addr - xlen_t'(`HRU_MMIO_BASE);

  // A load into this window has side effects and needs extra bubbles
  // The offset form avoids building a base+size adder in the compare
  assign o_mmio_load_in_ma = i_ma_is_load &&
                             (i_ma_addr >= xlen_t'(`HRU_MMIO_BASE)) &&
                             (mmio_offset < xlen_t'(`HRU_MMIO_SIZE));

  // ====================================================================
  // Multiply and divide stall
  // ====================================================================

  // Multiply holds until the registered completion flag says the result
  // is valid this cycle
  // Divide just follows the busy level of the divider
  logic mul_stall;
  logic div_stall;
  assign mul_stall = i_id_is_multiply && !i_mul_completing_q;
  assign div_stall = i_id_is_divide && i_ex_div_busy;

  assign o_mul_div_stall = mul_stall || div_stall;

endmodule : hru_hazard_detect

//--- logic/hru_hazard_state.sv
`timescale 1ns/1ps

`include "hru_params.svh"

module hru_hazard_state (
  input  logic i_clk,
  input  logic i_pipeline_reset,
  input  logic i_pipeline_stall,
  input  logic i_pipeline_flush,
  input  logic i_ld_potential_hazard,
  input  logic i_mul_div_stall,
  input  logic i_ex_mul_done_next,
  input  logic i_id_is_csr,
  input  logic i_ma_is_load,
  input  logic i_mmio_load_in_ma,
  output logic o_mul_completing_q,
  output logic o_load_use_stall,
  output logic o_csr_read_stall,
  output logic o_mmio_stall,
  output logic o_mmio_read_pulse
);

  import hru_pkg::*;

  // ====================================================================
  // Multiply completion prediction
  // ====================================================================

  // The multiplier flags completion one cycle ahead
  // Registering it lines the flag up with the valid result
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      o_mul_completing_q <= 1'b0;
    end else begin
      o_mul_completing_q <= i_ex_mul_done_next;
    end
  end

  // ====================================================================
  // Load-use history
  // ====================================================================

  logic ld_hazard_q;
  logic is_load_q;

  // Capture the match only when the pipeline advances
  // A flush drops the younger instruction, and its hazard with it
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset || i_pipeline_flush) begin
      ld_hazard_q <= 1'b0;
    end else if (!i_pipeline_stall) begin
      ld_hazard_q <= i_ld_potential_hazard;
    end
  end

  // Set while the stalled load sits in MA, so the held hazard does not
  // stall a second time; cleared on the next advance
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      is_load_q <= 1'b0;
    end else if (!i_pipeline_stall || o_load_use_stall) begin
      is_load_q <= i_ma_is_load && !is_load_q && o_load_use_stall;
    end
  end

  // Always stall on a potential hazard; multiply/divide wins if both fire
  assign o_load_use_stall = ld_hazard_q && !is_load_q && !i_mul_div_stall;

  // ====================================================================
  // CSR read wait
  // ====================================================================

  // CSR read data is registered in the CSR file, one bubble covers it
  logic csr_wait_q;
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      csr_wait_q <= 1'b0;
    end else begin
      csr_wait_q <= i_id_is_csr && !csr_wait_q;
    end
  end

  assign o_csr_read_stall = i_id_is_csr && !csr_wait_q;

  // ====================================================================
  // MMIO load bubbles
  // ====================================================================

  mmio_cnt_t mmio_cnt;

  // Counts bubbles while stalled, restarts whenever the pipeline moves
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset || i_pipeline_flush || !i_pipeline_stall) begin
      mmio_cnt <= '0;
    end else if (o_mmio_stall) begin
      mmio_cnt <= mmio_cnt + 1'b1;
    end
  end

  assign o_mmio_stall = i_mmio_load_in_ma &&
                        (mmio_cnt < mmio_cnt_t'(`HRU_MMIO_STALL_CYCLES));

  // Side effect fires once, on the first bubble only
  assign o_mmio_read_pulse = i_mmio_load_in_ma && (mmio_cnt == '0);

endmodule : hru_hazard_state

//--- logic/hru_pipeline_ctrl.sv
`timescale 1ns/1ps

`include "hru_params.svh"

module hru_pipeline_ctrl (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_cache_reset_busy,
  input  logic i_mul_div_stall,
  input  logic i_load_use_stall,
  input  logic i_csr_read_stall,
  input  logic i_mmio_stall,
  input  logic i_stall_for_wfi,
  input  logic i_ex_branch_taken,
  input  logic i_trap_taken,
  input  logic i_mret_taken,
  output logic o_pipeline_reset,
  output logic o_stall,
  output logic o_flush,
  output logic o_stall_registered,
  output logic o_rst_done,
  output logic o_vld,
  output logic o_pc_vld
);

  import hru_pkg::*;

  // ====================================================================
  // Reset and stall
  // ====================================================================

  // The core stays in reset while the caches initialize
  assign o_pipeline_reset = i_rst || i_cache_reset_busy;
  assign o_rst_done       = !i_cache_reset_busy;

  logic stall_sources;
  assign stall_sources = |{i_mul_div_stall, i_load_use_stall, i_csr_read_stall,
                           i_mmio_stall, i_stall_for_wfi};

  // Trap or MRET redirects fetch, so nothing may hold the pipeline back
  // This is also what wakes the core out of WFI
  assign o_stall = stall_sources && !i_trap_taken && !i_mret_taken;

  // Cleared on flush so a post-flush cycle does not look like a stall exit
  always_ff @(posedge i_clk) begin
    if (o_pipeline_reset || o_flush) begin
      o_stall_registered <= 1'b0;
    end else begin
      o_stall_registered <= o_stall;
    end
  end

  // ====================================================================
  // Flush
  // ====================================================================

  logic branch_q;
  logic trap_q;
  logic mret_q;

  // Causes are dropped during a stall; held ones would flush the
  // correct instruction that arrives once the stall ends
  always_ff @(posedge i_clk) begin
    if (o_pipeline_reset || o_stall) begin
      branch_q <= 1'b0;
      trap_q   <= 1'b0;
      mret_q   <= 1'b0;
    end else begin
      branch_q <= i_ex_branch_taken;
      trap_q   <= i_trap_taken;
      mret_q   <= i_mret_taken;
    end
  end

  // Two flush cycles clear both PD and ID of wrong-path instructions
  assign o_flush = (i_ex_branch_taken || branch_q || i_trap_taken || trap_q ||
                    i_mret_taken || mret_q) && !o_stall;

  // ====================================================================
  // Valid flow
  // ====================================================================

  // A one walks in from bit 0 on every advance
  stage_vec_t valid_sr;
  always_ff @(posedge i_clk) begin
    if (o_pipeline_reset) begin
      valid_sr <= '0;
    end else if (!o_stall) begin
      valid_sr <= {valid_sr[`HRU_NUM_STAGES-2:0], 1'b1};
    end
  end

  // Retirement at the last stage, PC valid at ID
  assign o_vld    = valid_sr[`HRU_NUM_STAGES-1] && !o_stall;
  assign o_pc_vld = valid_sr[`HRU_NUM_STAGES-`HRU_PC_VALID_OFFSET] && !o_stall;

endmodule : hru_pipeline_ctrl

//--- logic/hru_pkg.sv
`include "hru_params.svh"

package hru_pkg;

  // Data memory address as seen by the MA stage
  typedef logic [`HRU_XLEN-1:0] xlen_t;

  // Architectural register index, x0 to x31
  typedef logic [4:0] reg_idx_t;

  // One bit per pipeline stage for the valid flow tracker
  typedef logic [`HRU_NUM_STAGES-1:0] stage_vec_t;

  // Counts MMIO bubbles, enough room for HRU_MMIO_STALL_CYCLES
  typedef logic [1:0] mmio_cnt_t;

  // No state machines live in this unit, so there is no enum here
  // Every decision is a level computed from registered flags

endpackage : hru_pkg

//--- tb/hru_asserts.sv
`timescale 1ns/1ps

module hru_asserts (
  input logic i_clk,
  input logic i_pipeline_reset,
  input logic i_stall,
  input logic i_flush,
  input logic i_trap_taken,
  input logic i_mmio_read_pulse,
  input logic i_vld
);

  int unsigned fail_count = 0;

  // A flush only happens on an advancing cycle
  a_stall_flush_excl : assert property (@(posedge i_clk) disable iff (i_pipeline_reset)
    !(i_stall && i_flush))
    else begin
      fail_count++;
      $error("stall and flush are high in the same cycle");
    end

  // Trap redirects fetch and wins over every stall source
  a_trap_blocks_stall : assert property (@(posedge i_clk) disable iff (i_pipeline_reset)
    i_trap_taken |-> !i_stall)
    else begin
      fail_count++;
      $error("stall stayed high while a trap was taken");
    end

  // While stalled the same load is still in MA and must not be read twice
  a_single_read_pulse : assert property (@(posedge i_clk) disable iff (i_pipeline_reset)
    (i_mmio_read_pulse && i_stall) |=> !i_mmio_read_pulse)
    else begin
      fail_count++;
      $error("MMIO read pulse repeated for the same load");
    end

  // Retirement is only signalled on an advancing cycle
  a_vld_no_stall : assert property (@(posedge i_clk) disable iff (i_pipeline_reset)
    i_vld |-> !i_stall)
    else begin
      fail_count++;
      $error("o_vld high during a stall");
    end

endmodule : hru_asserts

bind hazard_resolution_unit hru_asserts u_asserts (
  .i_clk             (i_clk),
  .i_pipeline_reset  (pipeline_reset),
  .i_stall           (o_stall),
  .i_flush           (o_flush),
  .i_trap_taken      (i_trap_taken),
  .i_mmio_read_pulse (o_mmio_read_pulse),
  .i_vld             (o_vld)
);

//--- tb/hru_clk_gen.sv
`timescale 1ns/1ps

module hru_clk_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic o_clk,
  output logic o_rst
);

  // Free running clock starting low
  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Reset drops 1 ns after an edge like every other stimulus
  initial begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_rst = 1'b0;
  end

endmodule : hru_clk_gen

//--- tb/tb_hazard_resolution_unit.sv
`timescale 1ns/1ps

`include "hru_params.svh"

module tb_hazard_resolution_unit;

  import hru_pkg::*;

  // ====================================================================
  // Constants and scenario types
  // ====================================================================

  localparam int CYCLE_LIMIT = 400;
  localparam int DRIVE_DELAY = 1;
  localparam int MUL_WAIT    = 1;
  localparam int DIV_BUSY    = 2;
  localparam int CRST_LEN    = 3;
  // Unstalled cycles from reset release to the first valid outputs
  localparam int PCV_LAT     = 3;
  localparam int VLD_LAT     = 6;

  typedef enum int {
    SC_BOOT, SC_LOAD_USE, SC_LOAD_X0, SC_MUL, SC_DIV, SC_CSR,
    SC_MMIO, SC_MMIO_OUT, SC_FLUSH, SC_WFI_TRAP, SC_CACHE_RST
  } scn_t;

  // Expected levels for one cycle of a scenario
  // The valid outputs are only compared where chk_valid is set
  typedef struct packed {
    logic stall;
    logic lu_stall;
    logic flush;
    logic pulse;
    logic rst_done;
    logic prst;
    logic chk_valid;
    logic pc_vld;
    logic vld;
  } exp_t;

  logic     i_clk;
  logic     i_rst;
  logic     i_cache_reset_busy;
  logic     i_id_is_load;
  logic     i_id_is_multiply;
  logic     i_id_is_divide;
  logic     i_id_is_csr;
  reg_idx_t i_id_dest_reg;
  reg_idx_t i_pd_src1;
  reg_idx_t i_pd_src2;
  logic     i_ex_div_busy;
  logic     i_ex_mul_done_next;
  logic     i_ex_branch_taken;
  logic     i_ma_is_load;
  xlen_t    i_ma_addr;
  logic     i_stall_for_wfi;
  logic     i_trap_taken;
  logic     i_mret_taken;
  logic     o_stall;
  logic     o_flush;
  logic     o_stall_registered;
  logic     o_load_use_stall;
  logic     o_mmio_read_pulse;
  logic     o_rst_done;
  logic     o_vld;
  logic     o_pc_vld;

  int       seed = 32'h7b40;
  reg_idx_t ld_rd;
  reg_idx_t ld_src1;
  reg_idx_t ld_src2;
  xlen_t    mmio_addr;
  int       flush_kind;
  int       n;
  string    flush_names [3] = '{"flush_branch", "flush_trap", "flush_mret"};

  string    cur_name;
  scn_t     cur_scn;
  int       cur_k;
  int       cur_len;
  logic     active = 1'b0;
  exp_t     exp_now;
  logic     exp_prev_stall = 1'b0;
  int       stall_seen;
  int       stall_want;
  int       pulse_seen;
  int       pulse_want;
  int       errors = 0;
  int       tests_run = 0;
  int       tests_failed = 0;
  int       cycle_cnt = 0;

  hru_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(10)) u_clk_gen (
    .o_clk (i_clk),
    .o_rst (i_rst)
  );

  hazard_resolution_unit u_dut (.*);

  // ====================================================================
  // Reference and compare
  // ====================================================================

  // Expected outputs in cycle k of a scenario, counted from its first drive
  function automatic exp_t ref_expect(input scn_t scn, input int k);
    exp_t e;
    e = '0;
    e.rst_done = 1'b1;
    case (scn)
      SC_BOOT: begin
        e.chk_valid = 1'b1;
        e.pc_vld    = (k >= PCV_LAT);
        e.vld       = (k >= VLD_LAT);
      end
      // One bubble in the cycle after the match was sampled
      SC_LOAD_USE: begin
        e.stall    = (k == 1);
        e.lu_stall = (k == 1);
      end
      // Held until the cycle after the done-next strobe
      SC_MUL:      e.stall = (k <= MUL_WAIT);
      SC_DIV:      e.stall = (k < DIV_BUSY);
      SC_CSR:      e.stall = (k == 0);
      SC_MMIO: begin
        e.stall = (k < `HRU_MMIO_STALL_CYCLES);
        e.pulse = (k == 0);
      end
      SC_FLUSH:    e.flush = (k < 2);
      // WFI holds two cycles and the trap in cycle 2 overrides it
      SC_WFI_TRAP: begin
        e.stall = (k < 2);
        e.flush = (k == 2) || (k == 3);
      end
      SC_CACHE_RST: begin
        e.rst_done  = (k >= CRST_LEN);
        e.prst      = (k < CRST_LEN);
        e.chk_valid = (k >= 1);
        e.pc_vld    = (k >= CRST_LEN + PCV_LAT);
        e.vld       = (k >= CRST_LEN + VLD_LAT);
      end
      default: e.stall = 1'b0;
    endcase
    return e;
  endfunction

  function automatic mmio_cnt_t to_cnt(input int count);
    return (count > 3) ? mmio_cnt_t'(3) : mmio_cnt_t'(count);
  endfunction

  task automatic check_bit(input string test, input string sig, input logic exp,
                           input logic act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: %s expected %b actual %b", test, sig, exp, act);
    end
  endtask

  task automatic check_cnt(input string test, input string what, input mmio_cnt_t exp,
                           input mmio_cnt_t act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: %s expected %0d actual %0d", test, what, exp, act);
    end
  endtask

  // Outputs settle 3 ns after the drive so the falling edge is a safe sample
  always @(negedge i_clk) begin
    if (active) begin
      exp_now = ref_expect(cur_scn, cur_k);
      if (cur_k == 0) begin
        stall_seen = 0;
        stall_want = 0;
        pulse_seen = 0;
        pulse_want = 0;
      end
      check_bit(cur_name, "o_stall", exp_now.stall, o_stall);
      check_bit(cur_name, "o_load_use_stall", exp_now.lu_stall, o_load_use_stall);
      // The registered stall trails the expected stall by one edge
      check_bit(cur_name, "o_stall_registered", exp_prev_stall, o_stall_registered);
      check_bit(cur_name, "o_flush", exp_now.flush, o_flush);
      check_bit(cur_name, "o_mmio_read_pulse", exp_now.pulse, o_mmio_read_pulse);
      check_bit(cur_name, "o_rst_done", exp_now.rst_done, o_rst_done);
      check_bit(cur_name, "pipeline_reset", exp_now.prst, u_dut.pipeline_reset);
      if (exp_now.chk_valid) begin
        check_bit(cur_name, "o_pc_vld", exp_now.pc_vld, o_pc_vld);
        check_bit(cur_name, "o_vld", exp_now.vld, o_vld);
      end
      stall_seen += (o_stall === 1'b1);
      stall_want += exp_now.stall;
      pulse_seen += (o_mmio_read_pulse === 1'b1);
      pulse_want += exp_now.pulse;
      if (cur_k == cur_len - 1) begin
        check_cnt(cur_name, "stall cycles", to_cnt(stall_want), to_cnt(stall_seen));
        check_cnt(cur_name, "read pulses", to_cnt(pulse_want), to_cnt(pulse_seen));
      end
      exp_prev_stall = exp_now.stall;
    end
  end

  // ====================================================================
  // Stimulus
  // ====================================================================

  task automatic step();
    @(posedge i_clk);
    #(DRIVE_DELAY);
  endtask

  // Everything idles unless the scenario drives it in cycle k
  task automatic drive_inputs(input scn_t scn, input int k);
    i_cache_reset_busy = (scn == SC_CACHE_RST) && (k < CRST_LEN);
    i_id_is_load       = (scn == SC_LOAD_USE || scn == SC_LOAD_X0) && (k == 0);
    i_id_dest_reg      = ld_rd;
    i_pd_src1          = ld_src1;
    i_pd_src2          = ld_src2;
    // The stalled load has moved on to MA during its bubble
    i_ma_is_load       = (scn == SC_LOAD_USE || scn == SC_LOAD_X0) && (k == 1);
    i_id_is_multiply   = (scn == SC_MUL) && (k <= MUL_WAIT + 1);
    i_ex_mul_done_next = (scn == SC_MUL) && (k == MUL_WAIT);
    i_id_is_divide     = (scn == SC_DIV) && (k <= DIV_BUSY);
    i_ex_div_busy      = (scn == SC_DIV) && (k < DIV_BUSY);
    i_id_is_csr        = (scn == SC_CSR) && (k <= 1);
    i_ma_addr          = mmio_addr;
    if (scn == SC_MMIO || scn == SC_MMIO_OUT) begin
      i_ma_is_load = (k <= `HRU_MMIO_STALL_CYCLES);
    end
    i_ex_branch_taken  = (scn == SC_FLUSH) && (k == 0) && (flush_kind == 0);
    i_mret_taken       = (scn == SC_FLUSH) && (k == 0) && (flush_kind == 2);
    i_trap_taken       = ((scn == SC_FLUSH) && (k == 0) && (flush_kind == 1)) ||
                         ((scn == SC_WFI_TRAP) && (k == 2));
    i_stall_for_wfi    = (scn == SC_WFI_TRAP) && (k <= 2);
  endtask

  task automatic pick_load_regs();
    ld_rd = reg_idx_t'($random(seed));
    if (ld_rd == '0) begin
      ld_rd = reg_idx_t'(1);
    end
    ld_src1 = reg_idx_t'($random(seed));
    ld_src2 = reg_idx_t'($random(seed));
    // Either source may carry the dependency
    if ($random(seed) & 1) begin
      ld_src1 = ld_rd;
    end else begin
      ld_src2 = ld_rd;
    end
  endtask

  task automatic run_test(input string name, input scn_t scn, input int len);
    int err_before;
    err_before = errors;
    cur_name   = name;
    cur_scn    = scn;
    cur_len    = len;
    for (int k = 0; k < len; k++) begin
      drive_inputs(scn, k);
      cur_k  = k;
      active = 1'b1;
      step();
    end
    active = 1'b0;
    tests_run++;
    if (errors == err_before) begin
      $display("test %-14s ok", name);
    end else begin
      tests_failed++;
      $display("test %-14s failed with %0d errors", name, errors - err_before);
    end
  endtask

  always @(posedge i_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles before the test sequence ended", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    ld_rd      = '0;
    ld_src1    = '0;
    ld_src2    = '0;
    mmio_addr  = '0;
    flush_kind = 0;
    drive_inputs(SC_BOOT, 0);
    @(negedge i_rst);
    run_test("boot", SC_BOOT, VLD_LAT + 2);
    for (n = 0; n < 3; n++) begin
      pick_load_regs();
      run_test($sformatf("load_use_%0d", n), SC_LOAD_USE, 5);
    end
    ld_rd   = '0;
    ld_src1 = '0;
    run_test("load_x0", SC_LOAD_X0, 4);
    run_test("mul", SC_MUL, MUL_WAIT + 4);
    run_test("div", SC_DIV, DIV_BUSY + 3);
    run_test("csr", SC_CSR, 4);
    // Word aligned address anywhere inside the window
    mmio_addr = xlen_t'(`HRU_MMIO_BASE) + (xlen_t'($random(seed)) % (`HRU_MMIO_SIZE / 4)) * 4;
    run_test("mmio_load", SC_MMIO, `HRU_MMIO_STALL_CYCLES + 3);
    mmio_addr = xlen_t'(`HRU_MMIO_BASE) + xlen_t'(`HRU_MMIO_SIZE);
    run_test("mmio_outside", SC_MMIO_OUT, 4);
    mmio_addr = '0;
    for (n = 0; n < 3; n++) begin
      flush_kind = n;
      run_test(flush_names[n], SC_FLUSH, 4);
    end
    run_test("wfi_trap", SC_WFI_TRAP, 6);
    run_test("cache_reset", SC_CACHE_RST, CRST_LEN + VLD_LAT + 2);
    $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, u_dut.u_asserts.fail_count);
    if (errors == 0 && tests_failed == 0 && u_dut.u_asserts.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : tb_hazard_resolution_unit
